// ==== Bender.yml ====
package:
  name: csr_pipe

sources:
  - csr_pkg.sv
  - csr_mem_if.sv
  - csr_wb_if.sv
  - csr_pipe_reg.sv
  - exc_arbiter.sv
  - csr_regfile.sv
  - csr_top.sv
  - target: test
    files:
      - tb_csr_top.sv

// ==== csr_mem_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface csr_mem_if;

    // per-slot records, MEM stage
    logic [csr_pkg::ecode_w-1:0] ecode_a, ecode_b;
    logic                        ecode_we_a, ecode_we_b;
    logic [csr_pkg::xlen-1:0]    badv_a, badv_b;
    logic                        badv_we_a, badv_we_b;
    logic                        ertn;

    // merged action from the arbiter
    logic [csr_pkg::ecode_w-1:0] ecode;
    logic                        ecode_we;
    logic [csr_pkg::xlen-1:0]    badv;
    logic                        badv_we;
    logic [csr_pkg::xlen-1:0]    era;
    logic                        era_we;
    logic                        era_en, eentry_en;
    logic                        store_state, restore_state;
    logic                        flush;
    logic [csr_pkg::xlen-1:0]    flush_pc;

    modport pipe (
        output ecode_a, ecode_b, ecode_we_a, ecode_we_b,
        output badv_a, badv_b, badv_we_a, badv_we_b, ertn,
        input  ecode, ecode_we, badv, badv_we, era, era_we, era_en, eentry_en,
        input  store_state, restore_state, flush, flush_pc
    );

    modport arb (
        input  ecode_a, ecode_b, ecode_we_a, ecode_we_b,
        input  badv_a, badv_b, badv_we_a, badv_we_b, ertn,
        output ecode, ecode_we, badv, badv_we, era, era_we, era_en, eentry_en,
        output store_state, restore_state, flush, flush_pc
    );

endinterface

`default_nettype wire

// ==== csr_pipe_reg.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_pipe_reg (
    input  wire logic                           clk,
    input  wire logic                           rstn,
    input  wire logic                           stall_dcache,
    input  wire logic                           stall_ex,
    input  wire logic                           ex_br_a,      // slot A redirects in EX
    input  wire logic [csr_pkg::csr_addr_w-1:0] ex_csr_waddr,
    input  wire logic [csr_pkg::xlen-1:0]       ex_csr_we,
    input  wire logic [csr_pkg::xlen-1:0]       ex_csr_wdata,
    input  wire logic                           ex_ertn,
    input  wire logic [csr_pkg::ecode_w-1:0]    ex_ecode_a,
    input  wire logic [csr_pkg::ecode_w-1:0]    ex_ecode_b,
    input  wire logic                           ex_ecode_we_a,
    input  wire logic                           ex_ecode_we_b,
    input  wire logic [csr_pkg::xlen-1:0]       ex_badv_a,
    input  wire logic [csr_pkg::xlen-1:0]       ex_badv_b,
    input  wire logic                           ex_badv_we_a,
    input  wire logic                           ex_badv_we_b,
    csr_mem_if.pipe                             mem,
    csr_wb_if.pipe                              wb
);

    logic [csr_pkg::csr_addr_w-1:0] mem_csr_waddr;
    logic [csr_pkg::xlen-1:0]       mem_csr_we;
    logic [csr_pkg::xlen-1:0]       mem_csr_wdata;
    logic                           int_q;  // interrupt seen one stage ago
    logic                           hold;
    logic                           int_take;
    logic                           ex_fault;

    assign hold     = stall_dcache | stall_ex;
    assign int_take = wb.interrupt & ~int_q;
    assign ex_fault = (|ex_ecode_a) | (|ex_ecode_b);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mem_csr_we       <= '0;
            mem.ertn         <= 1'b0;
            mem.ecode_we_a   <= 1'b0;
            mem.ecode_we_b   <= 1'b0;
            mem.badv_we_a    <= 1'b0;
            mem.badv_we_b    <= 1'b0;
            wb.csr_we        <= '0;
            wb.ecode_we      <= 1'b0;
            wb.badv_we       <= 1'b0;
            wb.era_we        <= 1'b0;
            wb.store_state   <= 1'b0;
            wb.restore_state <= 1'b0;
            wb.flush         <= 1'b0;
            int_q            <= 1'b0;
        end else if (wb.flush) begin
            mem_csr_we       <= '0;
            mem.ertn         <= 1'b0;
            mem.ecode_we_a   <= 1'b0;
            mem.ecode_we_b   <= 1'b0;
            mem.badv_we_a    <= 1'b0;
            mem.badv_we_b    <= 1'b0;
            wb.csr_we        <= '0;
            // only a fresh interrupt survives the flush
            wb.ecode_we      <= int_take;
            wb.badv_we       <= 1'b0;
            wb.era_we        <= int_take;
            wb.store_state   <= int_take;
            wb.restore_state <= 1'b0;
            wb.flush         <= int_take;
            int_q            <= wb.interrupt;
        end else if (!hold) begin
            if (ex_br_a) begin
                mem_csr_we     <= '0; // wrong-path slot
                mem.ertn       <= 1'b0;
                mem.ecode_we_a <= 1'b0;
                mem.ecode_we_b <= 1'b0;
                mem.badv_we_a  <= 1'b0;
                mem.badv_we_b  <= 1'b0;
            end else begin
                mem_csr_we     <= ex_csr_we;
                mem.ertn       <= ex_ertn & ~ex_fault;
                mem.ecode_we_a <= ex_ecode_we_a;
                mem.ecode_we_b <= ex_ecode_we_b;
                mem.badv_we_a  <= ex_badv_we_a;
                mem.badv_we_b  <= ex_badv_we_b;
            end
            wb.csr_we        <= (|mem.ecode) ? '0 : mem_csr_we; // faulting op writes nothing
            wb.ecode_we      <= mem.ecode_we;
            wb.badv_we       <= mem.badv_we;
            wb.era_we        <= mem.era_we;
            // state change only rides with its redirect
            wb.store_state   <= mem.store_state & mem.eentry_en;
            wb.restore_state <= mem.restore_state & mem.era_en;
            wb.flush         <= mem.flush;
            int_q            <= wb.interrupt;
        end
    end

    // payload, qualified by the control bits above
    always_ff @(posedge clk) begin
        if (!hold && !wb.flush) begin
            mem_csr_waddr <= ex_csr_waddr;
            mem_csr_wdata <= ex_csr_wdata;
            mem.ecode_a   <= ex_ecode_a;
            mem.ecode_b   <= ex_ecode_b;
            mem.badv_a    <= ex_badv_a;
            mem.badv_b    <= ex_badv_b;
        end
        if (!hold || wb.flush) begin
            wb.csr_waddr <= mem_csr_waddr;
            wb.csr_wdata <= mem_csr_wdata;
            wb.ecode     <= mem.ecode;
            wb.badv      <= mem.badv;
            wb.era       <= mem.era;
            wb.flush_pc  <= mem.flush_pc;
        end
    end

endmodule

`default_nettype wire

// ==== csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    localparam int csr_addr_w = 14;
    localparam int xlen       = 32;
    localparam int ecode_w    = 7;

    // csr addresses
    localparam logic [csr_addr_w-1:0] csr_crmd   = 14'h000;
    localparam logic [csr_addr_w-1:0] csr_prmd   = 14'h001;
    localparam logic [csr_addr_w-1:0] csr_ecfg   = 14'h004;
    localparam logic [csr_addr_w-1:0] csr_estat  = 14'h005;
    localparam logic [csr_addr_w-1:0] csr_era    = 14'h006;
    localparam logic [csr_addr_w-1:0] csr_badv   = 14'h007;
    localparam logic [csr_addr_w-1:0] csr_eentry = 14'h00c;

    // exception codes
    localparam logic [ecode_w-1:0] ecode_int = 7'h00;
    localparam logic [ecode_w-1:0] ecode_ade = 7'h08; // fetch address error
    localparam logic [ecode_w-1:0] ecode_ale = 7'h09; // misaligned access
    localparam logic [ecode_w-1:0] ecode_sys = 7'h0b;

    // plv 0, ie 0, da 1
    localparam logic [xlen-1:0] crmd_reset   = 32'h0000_0008;
    localparam logic [xlen-1:0] eentry_reset = 32'h1c00_8000;

    // plv and ie together, saved to prmd on entry
    localparam int st_w = 3;
    localparam int crmd_ie_bit = 2;

    localparam int ecfg_lie_bit = 0;
    localparam int estat_hwi0_bit = 2;
    localparam int estat_ecode_lsb = 16;

endpackage

`default_nettype wire

// ==== csr_regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_regfile (
    input  wire logic                           clk,
    input  wire logic                           rstn,
    input  wire logic                           irq,
    input  wire logic [csr_pkg::csr_addr_w-1:0] csr_raddr,
    csr_wb_if.file                              wb,
    output      logic [csr_pkg::xlen-1:0]       csr_rdata,
    output      logic [csr_pkg::xlen-1:0]       eentry,
    output      logic [csr_pkg::xlen-1:0]       era_csr
);

    logic [csr_pkg::xlen-1:0] crmd;
    logic [csr_pkg::xlen-1:0] prmd;
    logic [csr_pkg::xlen-1:0] ecfg;
    logic [csr_pkg::xlen-1:0] estat;
    logic [csr_pkg::xlen-1:0] era;
    logic [csr_pkg::xlen-1:0] badv;
    logic [csr_pkg::xlen-1:0] eentry_q;

    // old value with masked bits replaced
    function automatic logic [csr_pkg::xlen-1:0] merge(
        input logic [csr_pkg::xlen-1:0] old,
        input logic [csr_pkg::xlen-1:0] mask,
        input logic [csr_pkg::xlen-1:0] data
    );
        return (old & ~mask) | (data & mask);
    endfunction

    always_ff @(posedge clk) begin
        if (!rstn) begin
            crmd     <= csr_pkg::crmd_reset;
            prmd     <= '0;
            ecfg     <= '0;
            estat    <= '0;
            era      <= '0;
            badv     <= '0;
            eentry_q <= csr_pkg::eentry_reset;
        end else begin
            if (|wb.csr_we) begin
                case (wb.csr_waddr)
                    csr_pkg::csr_crmd:   crmd     <= merge(crmd, wb.csr_we, wb.csr_wdata);
                    csr_pkg::csr_prmd:   prmd     <= merge(prmd, wb.csr_we, wb.csr_wdata);
                    csr_pkg::csr_ecfg:   ecfg     <= merge(ecfg, wb.csr_we, wb.csr_wdata);
                    csr_pkg::csr_estat:  estat    <= merge(estat, wb.csr_we, wb.csr_wdata);
                    csr_pkg::csr_era:    era      <= merge(era, wb.csr_we, wb.csr_wdata);
                    csr_pkg::csr_badv:   badv     <= merge(badv, wb.csr_we, wb.csr_wdata);
                    csr_pkg::csr_eentry: eentry_q <= merge(eentry_q, wb.csr_we, wb.csr_wdata);
                    default: ;
                endcase
            end

            // exception entry, save plv/ie and drop to kernel
            if (wb.store_state) begin
                prmd[csr_pkg::st_w-1:0] <= crmd[csr_pkg::st_w-1:0];
                crmd[csr_pkg::st_w-1:0] <= '0;
            end
            if (wb.restore_state) begin
                crmd[csr_pkg::st_w-1:0] <= prmd[csr_pkg::st_w-1:0];
            end

            if (wb.ecode_we) begin
                estat[csr_pkg::estat_ecode_lsb +: csr_pkg::ecode_w] <= wb.ecode;
            end
            if (wb.era_we) begin
                era <= wb.era;
            end
            if (wb.badv_we) begin
                badv <= wb.badv;
            end

            estat[csr_pkg::estat_hwi0_bit] <= irq; // hw owned
        end
    end

    assign wb.interrupt = irq & ecfg[csr_pkg::ecfg_lie_bit] & crmd[csr_pkg::crmd_ie_bit];

    always_comb begin
        case (csr_raddr)
            csr_pkg::csr_crmd:   csr_rdata = crmd;
            csr_pkg::csr_prmd:   csr_rdata = prmd;
            csr_pkg::csr_ecfg:   csr_rdata = ecfg;
            csr_pkg::csr_estat:  csr_rdata = estat;
            csr_pkg::csr_era:    csr_rdata = era;
            csr_pkg::csr_badv:   csr_rdata = badv;
            csr_pkg::csr_eentry: csr_rdata = eentry_q;
            default:             csr_rdata = '0;
        endcase
    end

    assign eentry  = eentry_q;
    assign era_csr = era;

endmodule

`default_nettype wire

// ==== csr_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_top (
    input  wire logic                           clk,
    input  wire logic                           rstn,
    input  wire logic                           stall_dcache,
    input  wire logic                           stall_ex,
    input  wire logic                           ex_br_a,
    input  wire logic [csr_pkg::csr_addr_w-1:0] ex_csr_waddr,
    input  wire logic [csr_pkg::xlen-1:0]       ex_csr_we,
    input  wire logic [csr_pkg::xlen-1:0]       ex_csr_wdata,
    input  wire logic                           ex_ertn,
    input  wire logic [csr_pkg::ecode_w-1:0]    ex_ecode_a,
    input  wire logic [csr_pkg::ecode_w-1:0]    ex_ecode_b,
    input  wire logic                           ex_ecode_we_a,
    input  wire logic                           ex_ecode_we_b,
    input  wire logic [csr_pkg::xlen-1:0]       ex_badv_a,
    input  wire logic [csr_pkg::xlen-1:0]       ex_badv_b,
    input  wire logic                           ex_badv_we_a,
    input  wire logic                           ex_badv_we_b,
    input  wire logic [csr_pkg::xlen-1:0]       mem_pc_a,
    input  wire logic [csr_pkg::xlen-1:0]       mem_pc_b,
    input  wire logic                           irq,
    input  wire logic [csr_pkg::csr_addr_w-1:0] csr_raddr,
    output      logic [csr_pkg::xlen-1:0]       csr_rdata,
    output      logic                           flush,
    output      logic [csr_pkg::xlen-1:0]       flush_pc
);

    csr_mem_if mem_bus ();
    csr_wb_if  wb_bus ();

    logic [csr_pkg::xlen-1:0] eentry;
    logic [csr_pkg::xlen-1:0] era_csr;

    csr_pipe_reg u_pipe (
        .clk(clk), .rstn(rstn), .stall_dcache(stall_dcache), .stall_ex(stall_ex),
        .ex_br_a(ex_br_a), .ex_csr_waddr(ex_csr_waddr), .ex_csr_we(ex_csr_we),
        .ex_csr_wdata(ex_csr_wdata), .ex_ertn(ex_ertn),
        .ex_ecode_a(ex_ecode_a), .ex_ecode_b(ex_ecode_b),
        .ex_ecode_we_a(ex_ecode_we_a), .ex_ecode_we_b(ex_ecode_we_b),
        .ex_badv_a(ex_badv_a), .ex_badv_b(ex_badv_b),
        .ex_badv_we_a(ex_badv_we_a), .ex_badv_we_b(ex_badv_we_b),
        .mem(mem_bus.pipe), .wb(wb_bus.pipe)
    );

    exc_arbiter u_arb (
        .mem_pc_a(mem_pc_a), .mem_pc_b(mem_pc_b), .eentry(eentry), .era_csr(era_csr),
        .mem(mem_bus.arb), .interrupt(wb_bus.interrupt)
    );

    csr_regfile u_file (
        .clk(clk), .rstn(rstn), .irq(irq), .csr_raddr(csr_raddr), .wb(wb_bus.file),
        .csr_rdata(csr_rdata), .eentry(eentry), .era_csr(era_csr)
    );

    // redirect straight from the WB registers
    assign flush    = wb_bus.flush;
    assign flush_pc = wb_bus.flush_pc;

endmodule

`default_nettype wire

// ==== csr_wb_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface csr_wb_if;

    logic [csr_pkg::csr_addr_w-1:0] csr_waddr;
    logic [csr_pkg::xlen-1:0]       csr_we;    // bit mask
    logic [csr_pkg::xlen-1:0]       csr_wdata;

    logic [csr_pkg::ecode_w-1:0]    ecode;
    logic                           ecode_we;
    logic [csr_pkg::xlen-1:0]       badv;
    logic                           badv_we;
    logic [csr_pkg::xlen-1:0]       era;
    logic                           era_we;
    logic                           store_state;
    logic                           restore_state;
    logic                           flush;
    logic [csr_pkg::xlen-1:0]       flush_pc;

    // pending interrupt, file back to pipe
    logic                           interrupt;

    modport pipe (
        output csr_waddr, csr_we, csr_wdata,
        output ecode, ecode_we, badv, badv_we, era, era_we,
        output store_state, restore_state, flush, flush_pc,
        input  interrupt
    );

    modport file (
        input  csr_waddr, csr_we, csr_wdata,
        input  ecode, ecode_we, badv, badv_we, era, era_we,
        input  store_state, restore_state, flush, flush_pc,
        output interrupt
    );

endinterface

`default_nettype wire

// ==== exc_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module exc_arbiter (
    input  wire logic [csr_pkg::xlen-1:0] mem_pc_a,
    input  wire logic [csr_pkg::xlen-1:0] mem_pc_b,
    input  wire logic [csr_pkg::xlen-1:0] eentry,
    input  wire logic [csr_pkg::xlen-1:0] era_csr,
    csr_mem_if.arb                        mem,
    input  wire logic                     interrupt
);

    always_comb begin
        mem.ecode         = '0;
        mem.ecode_we      = 1'b0;
        mem.badv          = '0;
        mem.badv_we       = 1'b0;
        mem.era           = '0;
        mem.era_we        = 1'b0;
        mem.era_en        = 1'b0;
        mem.eentry_en     = 1'b0;
        mem.store_state   = 1'b0;
        mem.restore_state = 1'b0;
        mem.flush         = 1'b0;
        mem.flush_pc      = '0;

        if (interrupt) begin
            mem.ecode    = csr_pkg::ecode_int;
            mem.ecode_we = 1'b1;
            mem.era      = mem_pc_a; // taken before slot A
            mem.era_we   = 1'b1;
        end else if (mem.ecode_we_a) begin
            mem.ecode    = mem.ecode_a;
            mem.ecode_we = 1'b1;
            mem.badv     = mem.badv_a;
            mem.badv_we  = mem.badv_we_a;
            mem.era      = mem_pc_a;
            mem.era_we   = 1'b1;
        end else if (mem.ecode_we_b) begin
            mem.ecode    = mem.ecode_b;
            mem.ecode_we = 1'b1;
            mem.badv     = mem.badv_b;
            mem.badv_we  = mem.badv_we_b;
            mem.era      = mem_pc_b;
            mem.era_we   = 1'b1;
        end else if (mem.ertn) begin
            mem.restore_state = 1'b1;
            mem.era_en        = 1'b1;
            mem.flush         = 1'b1;
            mem.flush_pc      = era_csr;
        end

        // common exception entry
        if (mem.ecode_we) begin
            mem.store_state = 1'b1;
            mem.eentry_en   = 1'b1;
            mem.flush       = 1'b1;
            mem.flush_pc    = eentry;
        end
    end

endmodule

`default_nettype wire

// ==== sim.f ====
csr_pkg.sv
csr_mem_if.sv
csr_wb_if.sv
csr_pipe_reg.sv
exc_arbiter.sv
csr_regfile.sv
csr_top.sv
tb_csr_top.sv

// ==== tb_csr_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_csr_top;

    localparam int n_wr  = 40;
    localparam int n_exc = 12;
    // cycles for reset and sweep, each write, each exception round and the irq test
    localparam int sched_cycles  = 16 + n_wr * 7 + n_exc * 24 + 40;
    localparam int timeout_limit = 4 * sched_cycles;

    localparam int op_write = 0;
    localparam int op_exc   = 1;
    localparam int op_ertn  = 2;

    logic                           clk, rstn, stall_dcache, stall_ex, ex_br_a, ex_ertn, irq;
    logic [csr_pkg::csr_addr_w-1:0] ex_csr_waddr, csr_raddr;
    logic [csr_pkg::xlen-1:0]       ex_csr_we, ex_csr_wdata, ex_badv_a, ex_badv_b;
    logic [csr_pkg::xlen-1:0]       mem_pc_a, mem_pc_b, csr_rdata, flush_pc;
    logic [csr_pkg::ecode_w-1:0]    ex_ecode_a, ex_ecode_b;
    logic                           ex_ecode_we_a, ex_ecode_we_b, ex_badv_we_a, ex_badv_we_b;
    logic                           flush;

    logic [csr_pkg::xlen-1:0] shadow [0:15]; // model csrs by address
    logic                     exp_flush;
    logic [csr_pkg::xlen-1:0] exp_flush_pc;
    logic                     chk_en;
    logic [15:0]              lfsr;
    int                       cycle_cnt = 0;

    csr_top dut (
        .clk(clk), .rstn(rstn), .stall_dcache(stall_dcache), .stall_ex(stall_ex),
        .ex_br_a(ex_br_a), .ex_csr_waddr(ex_csr_waddr), .ex_csr_we(ex_csr_we),
        .ex_csr_wdata(ex_csr_wdata), .ex_ertn(ex_ertn),
        .ex_ecode_a(ex_ecode_a), .ex_ecode_b(ex_ecode_b),
        .ex_ecode_we_a(ex_ecode_we_a), .ex_ecode_we_b(ex_ecode_we_b),
        .ex_badv_a(ex_badv_a), .ex_badv_b(ex_badv_b),
        .ex_badv_we_a(ex_badv_we_a), .ex_badv_we_b(ex_badv_we_b),
        .mem_pc_a(mem_pc_a), .mem_pc_b(mem_pc_b), .irq(irq), .csr_raddr(csr_raddr),
        .csr_rdata(csr_rdata), .flush(flush), .flush_pc(flush_pc)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [csr_pkg::csr_addr_w-1:0] csr_by_index(input int i);
        case (i)
            0:       return csr_pkg::csr_crmd;
            1:       return csr_pkg::csr_prmd;
            2:       return csr_pkg::csr_ecfg;
            3:       return csr_pkg::csr_eentry;
            4:       return csr_pkg::csr_era;
            5:       return csr_pkg::csr_estat;
            default: return csr_pkg::csr_badv;
        endcase
    endfunction

    function automatic logic [csr_pkg::ecode_w-1:0] pick_ecode();
        case (rand_bits(2) % 3)
            0:       return csr_pkg::ecode_ade;
            1:       return csr_pkg::ecode_ale;
            default: return csr_pkg::ecode_sys;
        endcase
    endfunction

    // shadow csr state after one committed write, exception entry or ertn
    function automatic void csr_model(
        input int                           op,
        input logic [csr_pkg::csr_addr_w-1:0] addr,
        input logic [csr_pkg::xlen-1:0]     mask,
        input logic [csr_pkg::xlen-1:0]     data,
        input logic [csr_pkg::ecode_w-1:0]  ecode,
        input logic [csr_pkg::xlen-1:0]     era,
        input logic [csr_pkg::xlen-1:0]     badv,
        input logic                         badv_we
    );
        logic [csr_pkg::xlen-1:0] crmd;
        logic [csr_pkg::xlen-1:0] prmd;
        crmd = shadow[csr_pkg::csr_crmd];
        prmd = shadow[csr_pkg::csr_prmd];
        case (op)
            op_write: shadow[addr] = (shadow[addr] & ~mask) | (data & mask);
            op_exc: begin
                shadow[csr_pkg::csr_prmd] = {prmd[31:3], crmd[2:0]}; // plv and ie saved
                shadow[csr_pkg::csr_crmd] = {crmd[31:3], 3'b000};
                shadow[csr_pkg::csr_estat][csr_pkg::estat_ecode_lsb +: csr_pkg::ecode_w] = ecode;
                shadow[csr_pkg::csr_era]  = era;
                if (badv_we) begin
                    shadow[csr_pkg::csr_badv] = badv;
                end
            end
            op_ertn: shadow[csr_pkg::csr_crmd] = {crmd[31:3], prmd[2:0]};
            default: ;
        endcase
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "simulation stopped");
    endtask

    // compare mid-cycle while outputs are stable
    always @(negedge clk) begin
        if (chk_en) begin
            assert (flush === exp_flush)
                else stop_with_failure($sformatf("error: flush = %h, expected %h",
                                                 flush, exp_flush));
            if (exp_flush) begin
                assert (flush_pc === exp_flush_pc)
                    else stop_with_failure($sformatf("error: flush_pc = %h, expected %h",
                                                     flush_pc, exp_flush_pc));
            end
            assert (csr_rdata === shadow[csr_raddr[3:0]])
                else stop_with_failure($sformatf("error: csr_rdata = %h, expected %h at %h",
                                                 csr_rdata, shadow[csr_raddr[3:0]], csr_raddr));
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > timeout_limit) begin
            stop_with_failure($sformatf("timeout: test did not end within %0d cycles",
                                        timeout_limit));
        end
    end

    task automatic next_cycle;
        @(posedge clk);
        #10;
    endtask

    task automatic drive_bubble;
        stall_ex      = 1'b0;
        stall_dcache  = 1'b0;
        ex_br_a       = 1'b0;
        ex_csr_we     = '0;
        ex_ertn       = 1'b0;
        ex_ecode_a    = '0;
        ex_ecode_b    = '0;
        ex_ecode_we_a = 1'b0;
        ex_ecode_we_b = 1'b0;
        ex_badv_we_a  = 1'b0;
        ex_badv_we_b  = 1'b0;
    endtask

    task automatic sweep_csrs;
        for (int i = 0; i < 7; i++) begin
            csr_raddr = csr_by_index(i);
            next_cycle;
        end
    endtask

    // mode 0 plain, 1 stall_ex, 2 stall_dcache, 3 branch kill
    task automatic write_csr(
        input logic [csr_pkg::csr_addr_w-1:0] addr,
        input logic [csr_pkg::xlen-1:0]       mask,
        input logic [csr_pkg::xlen-1:0]       data,
        input int                             mode,
        input int                             stall_n
    );
        ex_csr_waddr = addr;
        ex_csr_we    = mask;
        ex_csr_wdata = data;
        ex_br_a      = (mode == 3);
        stall_ex     = (mode == 1);
        stall_dcache = (mode == 2);
        csr_raddr    = addr;
        if (mode == 1 || mode == 2) begin
            repeat (stall_n) next_cycle;
            stall_ex     = 1'b0;
            stall_dcache = 1'b0;
        end
        next_cycle; // captured in EX
        drive_bubble;
        next_cycle;
        next_cycle;
        if (mode != 3) begin
            csr_model(op_write, addr, mask, data, '0, '0, '0, 1'b0);
        end
        next_cycle;
    endtask

    // slot B always faults and slot A too when two_slot
    task automatic raise_exception(input logic two_slot, input logic with_ertn);
        logic [csr_pkg::ecode_w-1:0] code_a, code_b;
        logic [csr_pkg::xlen-1:0]    va, vb, pc_a, pc_b;
        logic                        bwe_a, bwe_b;
        code_a        = pick_ecode();
        code_b        = pick_ecode();
        va            = rand_bits(32);
        vb            = rand_bits(32);
        bwe_a         = rand_bits(1) != 0;
        bwe_b         = rand_bits(1) != 0;
        pc_a          = rand_bits(30) << 2;
        pc_b          = pc_a + 32'd4;
        ex_ecode_a    = two_slot ? code_a : '0;
        ex_ecode_we_a = two_slot;
        ex_badv_a     = va;
        ex_badv_we_a  = two_slot & bwe_a;
        ex_ecode_b    = code_b;
        ex_ecode_we_b = 1'b1;
        ex_badv_b     = vb;
        ex_badv_we_b  = bwe_b;
        ex_ertn       = with_ertn;
        ex_csr_waddr  = csr_by_index(rand_bits(3) % 5); // must not commit
        ex_csr_we     = rand_bits(32);
        ex_csr_wdata  = rand_bits(32);
        mem_pc_a      = pc_a;
        mem_pc_b      = pc_b;
        csr_raddr     = csr_pkg::csr_crmd;
        next_cycle;
        drive_bubble;
        next_cycle;
        exp_flush_pc = shadow[csr_pkg::csr_eentry];
        exp_flush    = 1'b1;
        next_cycle;
        exp_flush = 1'b0;
        if (two_slot) begin
            csr_model(op_exc, '0, '0, '0, code_a, pc_a, va, bwe_a);
        end else begin
            csr_model(op_exc, '0, '0, '0, code_b, pc_b, vb, bwe_b);
        end
        sweep_csrs;
    endtask

    task automatic return_from_exception;
        ex_ertn   = 1'b1;
        csr_raddr = csr_pkg::csr_crmd;
        next_cycle;
        drive_bubble;
        next_cycle;
        exp_flush_pc = shadow[csr_pkg::csr_era];
        exp_flush    = 1'b1;
        next_cycle;
        exp_flush = 1'b0;
        csr_model(op_ertn, '0, '0, '0, '0, '0, '0, 1'b0);
        sweep_csrs;
    endtask

    task automatic interrupt_test;
        logic [csr_pkg::xlen-1:0] pc;
        write_csr(csr_pkg::csr_ecfg, 32'h1 << csr_pkg::ecfg_lie_bit,
                  32'h1 << csr_pkg::ecfg_lie_bit, 0, 0);
        write_csr(csr_pkg::csr_crmd, 32'h1 << csr_pkg::crmd_ie_bit,
                  32'h1 << csr_pkg::crmd_ie_bit, 0, 0);
        pc        = rand_bits(30) << 2;
        mem_pc_a  = pc;
        csr_raddr = csr_pkg::csr_crmd;
        irq       = 1'b1;
        next_cycle;
        shadow[csr_pkg::csr_estat][csr_pkg::estat_hwi0_bit] = 1'b1;
        exp_flush_pc = shadow[csr_pkg::csr_eentry];
        exp_flush    = 1'b1;
        next_cycle;
        exp_flush = 1'b0;
        csr_model(op_exc, '0, '0, '0, csr_pkg::ecode_int, pc, '0, 1'b0);
        repeat (4) next_cycle; // irq still high but ie now clear
        sweep_csrs;
        irq       = 1'b0;
        csr_raddr = csr_pkg::csr_crmd;
        next_cycle;
        shadow[csr_pkg::csr_estat][csr_pkg::estat_hwi0_bit] = 1'b0;
        irq = 1'b1;
        next_cycle;
        shadow[csr_pkg::csr_estat][csr_pkg::estat_hwi0_bit] = 1'b1;
        repeat (3) next_cycle;
        irq = 1'b0;
        next_cycle;
        shadow[csr_pkg::csr_estat][csr_pkg::estat_hwi0_bit] = 1'b0;
        return_from_exception;
    endtask

    initial begin
        lfsr         = 16'd52717;
        rstn         = 1'b0;
        drive_bubble;
        ex_csr_waddr = '0;
        ex_csr_wdata = '0;
        ex_badv_a    = '0;
        ex_badv_b    = '0;
        mem_pc_a     = '0;
        mem_pc_b     = '0;
        irq          = 1'b0;
        csr_raddr    = csr_pkg::csr_crmd;
        exp_flush    = 1'b0;
        exp_flush_pc = '0;
        chk_en       = 1'b0;
        for (int i = 0; i < 16; i++) begin
            shadow[i] = '0;
        end
        shadow[csr_pkg::csr_crmd]   = csr_pkg::crmd_reset;
        shadow[csr_pkg::csr_eentry] = csr_pkg::eentry_reset;

        repeat (8) @(posedge clk);
        #10;
        rstn   = 1'b1;
        chk_en = 1'b1;
        sweep_csrs;

        for (int i = 0; i < n_wr; i++) begin
            write_csr(csr_by_index(rand_bits(3) % 5), rand_bits(32), rand_bits(32),
                      rand_bits(2), 1 + rand_bits(2) % 3);
        end

        for (int i = 0; i < n_exc; i++) begin
            write_csr(csr_pkg::csr_crmd, 32'h7, rand_bits(32), 0, 0); // fresh plv and ie
            raise_exception(rand_bits(1) != 0, rand_bits(1) != 0);
            return_from_exception;
        end

        interrupt_test;

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire
